// ==== tile_mem.f ====
+incdir+hw
hw/tile_mem_pkg.sv
hw/tile_addr_decode.sv
hw/tile_l1_spm.sv
hw/tile_l2_bridge.sv
hw/tile_mem_top.sv
verif/tile_mem_assert.sv
verif/tile_mem_checker.sv
verif/tile_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the tile memory testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tile_mem_tb \
  -f tile_mem.f \
  --Mdir obj_dir -o tile_mem_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status, see build.log"
  exit 1
fi

./obj_dir/tile_mem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// ==== verif/tile_mem_tb.sv ====
// Testbench top; random APB traffic from an LFSR, L2 memory responder, watchdog and verdict
`timescale 1ns/1ps
`default_nettype none

`include "tile_mem_config.svh"

module tile_mem_tb;

  localparam int NUM_XFERS  = 400;
  localparam int WORST_CYC  = 40; // Longest L2 transfer plus enable stalls
  localparam int TIMEOUT_NS = NUM_XFERS * WORST_CYC * 8 + 2000;

  logic        clk_i = 1'b0;
  logic        rstn_i;
  logic        tile_enable_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [31:0] paddr_i;
  logic [31:0] pwdata_i;
  logic [3:0]  pstrb_i;
  logic        pready_o;
  logic [31:0] prdata_o;
  logic        pslverr_o;
  logic        l2_psel_o;
  logic        l2_penable_o;
  logic        l2_pwrite_o;
  logic [31:0] l2_paddr_o;
  logic [31:0] l2_pwdata_o;
  logic [3:0]  l2_pstrb_o;
  logic        l2_pready_i  = 1'b0;
  logic [31:0] l2_prdata_i  = '0;
  logic        l2_pslverr_i = 1'b0;

  logic [15:0] lfsr = 16'd8;
  logic [31:0] l2_mem [1024];
  logic [1:0]  l2_wait;     // Wait states for the current L2 transfer
  logic        l2_fail = 1'b0; // L2 memory answers this transfer with an error
  int          l2_cnt;
  int          low_left = 0; // Cycles the enable stays low
  logic [31:0] last_l1 = `TILE_L1_BASE;
  logic [31:0] last_l2 = `TILE_L2_BASE;

  always #4 clk_i = ~clk_i;

  tile_mem_top i_tile_mem_top (.*);

  tile_mem_checker i_tile_mem_checker (.*);

  bind tile_mem_top tile_mem_assert i_tile_mem_assert (
    .clk_i(clk_i), .rstn_i(rstn_i), .tile_enable_i(tile_enable_i),
    .tile_enable(tile_enable), .psel_i(psel_i), .penable_i(penable_i),
    .pready_o(pready_o), .pslverr_o(pslverr_o), .l2_psel_o(l2_psel_o),
    .l2_penable_o(l2_penable_o), .l2_pwrite_o(l2_pwrite_o), .l2_paddr_o(l2_paddr_o),
    .l2_pready_i(l2_pready_i)
  );

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // L2 memory on the requester port with l2_wait extra cycles before pready
  initial for (int i = 0; i < 1024; i++) l2_mem[i] = 32'hC0DE_0000 ^ (i * 32'h0001_0003);

  always @(posedge clk_i) begin
    l2_pready_i  <= 1'b0;
    l2_pslverr_i <= 1'b0;
    if (l2_psel_o && !l2_penable_o) begin
      l2_cnt <= 0;
    end else if (l2_psel_o && l2_penable_o && !l2_pready_i) begin
      if (l2_cnt == int'(l2_wait)) begin
        l2_pready_i  <= 1'b1;
        l2_pslverr_i <= l2_fail; // A failed write leaves the memory unchanged
        l2_prdata_i  <= l2_mem[l2_paddr_o[11:2]];
        if (l2_pwrite_o && !l2_fail) begin
          for (int i = 0; i < 4; i++) begin
            if (l2_pstrb_o[i]) l2_mem[l2_paddr_o[11:2]][8*i +: 8] <= l2_pwdata_o[8*i +: 8];
          end
        end
      end else begin
        l2_cnt <= l2_cnt + 1;
      end
    end
  end

  // One clock edge with random short enable drops
  task automatic tick();
    logic [31:0] v;
    @(posedge clk_i);
    if (low_left > 0) begin
      low_left--;
      tile_enable_i <= 1'b0;
    end else begin
      tile_enable_i <= 1'b1;
      rand_bits(4, v);
      if (v[3:0] == 4'd0) begin
        rand_bits(2, v);
        low_left = int'(v[1:0]) + 1;
      end
    end
  endtask

  task automatic run_transfer();
    logic [31:0] win, reuse, idx, wr, data, strb, wt, ferr, addr;
    logic        done;
    rand_bits(2, win);
    rand_bits(1, reuse);
    rand_bits(10, idx);
    rand_bits(1, wr);
    rand_bits(32, data);
    rand_bits(4, strb);
    rand_bits(2, wt);
    rand_bits(3, ferr);
    if (win[1] == 1'b0) begin // Half of the traffic into L1
      addr = reuse[0] ? last_l1 : `TILE_L1_BASE + {22'd0, idx[7:0], 2'b00};
      last_l1 = addr;
    end else if (win[0] == 1'b0) begin
      addr = reuse[0] ? last_l2 : `TILE_L2_BASE + {20'd0, idx[9:0], 2'b00};
      last_l2 = addr;
    end else begin // Just past either window
      addr = (idx[9] ? `TILE_L2_BASE + `TILE_L2_SIZE : `TILE_L1_BASE + 32'h400) +
             {23'd0, idx[8:0]};
    end
    l2_wait = wt[1:0];
    l2_fail = (ferr[2:0] == 3'd0); // One L2 transfer in eight fails
    tick();
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr[0];
    paddr_i   <= {addr[31:2], 2'b00};
    pwdata_i  <= data;
    pstrb_i   <= wr[0] ? strb[3:0] : 4'd0;
    tick();
    penable_i <= 1'b1;
    do begin
      @(negedge clk_i);
      done = pready_o;
      if (!done) tick();
    end while (!done);
    tick();
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  initial begin
    rstn_i        = 1'b0;
    tile_enable_i = 1'b0;
    psel_i        = 1'b0;
    penable_i     = 1'b0;
    pwrite_i      = 1'b0;
    paddr_i       = '0;
    pwdata_i      = '0;
    pstrb_i       = '0;
    repeat (8) @(posedge clk_i);
    rstn_i <= 1'b1;
    tile_enable_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    for (int n = 0; n < NUM_XFERS; n++) run_transfer();
    repeat (4) @(posedge clk_i);
    $display("Errors: %0d in %0d transfers", i_tile_mem_checker.err_count, NUM_XFERS);
    if (i_tile_mem_checker.err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog that ends a run with a stuck handshake
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: transfers did not finish within %0d ns", TIMEOUT_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/tile_mem_checker.sv ====
// Watches the tile ports, models L1, L2 and the address map, and compares every completion
`timescale 1ns/1ps
`default_nettype none

`include "tile_mem_config.svh"

module tile_mem_checker (
  input wire                    clk_i,
  input wire                    rstn_i,
  input wire                    tile_enable_i,
  input wire                    psel_i,
  input wire                    penable_i,
  input wire                    pwrite_i,
  input wire [`TILE_ADDR_W-1:0] paddr_i,
  input wire [`TILE_DATA_W-1:0] pwdata_i,
  input wire [`TILE_STRB_W-1:0] pstrb_i,
  input wire                    pready_o,
  input wire [`TILE_DATA_W-1:0] prdata_o,
  input wire                    pslverr_o,
  input wire                    l2_psel_o,
  input wire                    l2_penable_o,
  input wire                    l2_pwrite_o,
  input wire [`TILE_ADDR_W-1:0] l2_paddr_o,
  input wire [`TILE_DATA_W-1:0] l2_pwdata_o,
  input wire [`TILE_STRB_W-1:0] l2_pstrb_o,
  input wire                    l2_pready_i,
  input wire                    l2_pslverr_i
);

  int          err_count = 0;
  logic [31:0] l1_mem [256]; // Whole L1 window by word index
  logic [31:0] l2_mem [1024];
  logic [31:0] cap_addr;
  logic [31:0] cap_wdata;
  logic [3:0]  cap_strb;
  logic        cap_write;
  logic [1:0]  cap_win; // 0 L1, 1 L2, 2 unmapped
  logic        en_d;      // Input enable one edge back equals the registered gate
  logic        en_low;    // Gate was closed during this transfer
  logic        l2_started;
  logic        l2_err;    // Error answer from the L2 memory
  int          acc_cnt;
  int          l2_cnt;

  // Initial L2 contents match the responder memory
  function automatic logic [31:0] l2_fill(input int idx);
    return 32'hC0DE_0000 ^ (idx * 32'h0001_0003);
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] wd,
                                        input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = wd[8*i +: 8];
    end
    return res;
  endfunction

  initial begin
    for (int i = 0; i < 256; i++) l1_mem[i] = '1; // Scratchpad starts all ones
    for (int i = 0; i < 1024; i++) l2_mem[i] = l2_fill(i);
  end

  always @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      en_d = 1'b0;
      acc_cnt = 0;
    end else begin
      if (psel_i && !penable_i) begin // Capture and classify in the setup cycle
        cap_addr  = paddr_i;
        cap_wdata = pwdata_i;
        cap_strb  = pstrb_i;
        cap_write = pwrite_i;
        if (paddr_i >= `TILE_L1_BASE && paddr_i < `TILE_L1_BASE + 32'h400) cap_win = 2'd0;
        else if (paddr_i >= `TILE_L2_BASE && paddr_i < `TILE_L2_BASE + `TILE_L2_SIZE)
          cap_win = 2'd1;
        else cap_win = 2'd2;
        acc_cnt    = 0;
        l2_cnt     = 0;
        l2_started = 1'b0;
        l2_err     = 1'b0;
        en_low     = !en_d;
      end
      if (psel_i && penable_i) begin
        acc_cnt++;
        if (!en_d) en_low = 1'b1;
      end
      if (l2_psel_o && !l2_penable_o) begin // L2 setup mirrors the request
        l2_started = 1'b1;
        if (cap_win != 2'd1) begin
          $display("Error at %0t: L2 transfer started for a non-L2 address", $time);
          err_count++;
        end else if (l2_paddr_o != cap_addr || l2_pwrite_o != cap_write ||
                     (cap_write && (l2_pwdata_o != cap_wdata || l2_pstrb_o != cap_strb))) begin
          $display("Fail %0t: L2 request %h differs from APB request %h", $time,
                   l2_paddr_o, cap_addr);
          err_count++;
        end
      end
      if (l2_psel_o && l2_penable_o) begin
        l2_cnt++;
        if (l2_pready_i) l2_err = l2_pslverr_i; // Memory answer that pslverr must follow
      end
      if (psel_i && penable_i && pready_o) begin
        check_completion();
      end
      en_d = tile_enable_i;
    end
  end

  task automatic check_completion();
    logic [31:0] exp;
    int          exp_acc;
    logic        exp_err;
    exp_err = (cap_win == 2'd2);
    if (cap_win == 2'd2) begin
      exp = '0;
      exp_acc = 1;
      if (l2_started) begin
        $display("Error at %0t: unmapped access reached the L2 port", $time);
        err_count++;
      end
    end else if (cap_win == 2'd0) begin
      exp = l1_mem[cap_addr[9:2]];
      exp_acc = 2; // One wait state
      if (cap_write) l1_mem[cap_addr[9:2]] = merge(exp, cap_wdata, cap_strb);
    end else begin
      exp = l2_mem[cap_addr[11:2]];
      exp_acc = l2_cnt + 3; // Issue, L2 setup, L2 access phases, answer
      exp_err = l2_err;
      if (cap_write && !l2_err) l2_mem[cap_addr[11:2]] = merge(exp, cap_wdata, cap_strb);
    end
    if (pslverr_o != exp_err) begin
      $display("Fail %0t: pslverr %b for address %h", $time, pslverr_o, cap_addr);
      err_count++;
    end
    if (!cap_write && !exp_err && prdata_o != exp) begin
      $display("Fail %0t: read %h got %h expected %h", $time, cap_addr, prdata_o, exp);
      err_count++;
    end
    if (!en_low && acc_cnt != exp_acc) begin
      $display("Fail %0t: %h took %0d access cycles, expected %0d", $time, cap_addr,
               acc_cnt, exp_acc);
      err_count++;
    end
  endtask

endmodule

`default_nettype wire

// ==== verif/tile_mem_assert.sv ====
// Concurrent checks on both APB ports and the enable gate, bound into the tile top
`timescale 1ns/1ps
`default_nettype none

`include "tile_mem_config.svh"

module tile_mem_assert (
  input wire                    clk_i,
  input wire                    rstn_i,
  input wire                    tile_enable_i, // Enable input of the top
  input wire                    tile_enable, // Registered gate inside the top
  input wire                    psel_i,
  input wire                    penable_i,
  input wire                    pready_o,
  input wire                    pslverr_o,
  input wire                    l2_psel_o,
  input wire                    l2_penable_o,
  input wire                    l2_pwrite_o,
  input wire [`TILE_ADDR_W-1:0] l2_paddr_o,
  input wire                    l2_pready_i
);

  // Completion only inside an access cycle and only errors end in the first one
  a_pready_access: assert property (@(posedge clk_i) disable iff (!rstn_i)
    pready_o |-> (psel_i && penable_i && (pslverr_o || $past(psel_i && penable_i))))
    else $error("pready_o outside an access cycle or without a wait state");

  // Nothing completes unless the input enable was high one cycle earlier
  a_pready_enable: assert property (@(posedge clk_i) disable iff (!rstn_i)
    pready_o |-> $past(tile_enable_i)) else $error("pready_o while the tile is disabled");

  // L2 requester holds address and control until its pready
  a_l2_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (l2_psel_o && !(l2_penable_o && l2_pready_i)) |=>
      (l2_psel_o && $stable(l2_paddr_o) && $stable(l2_pwrite_o)))
    else $error("L2 address or control changed during a transfer");

  // Enable must be high at the issue two cycles before the L2 setup
  a_l2_start: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $rose(l2_psel_o) |-> $past(tile_enable, 2)) else $error("L2 transfer started while disabled");

endmodule

`default_nettype wire

// ==== hw/tile_mem_top.sv ====
// Tile memory top; registers the tile enable and connects decode, L1 scratchpad and L2 bridge
`timescale 1ns/1ps
`default_nettype none

`include "tile_mem_config.svh"

module tile_mem_top (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  input  logic                    tile_enable_i,
  // APB completer from the processor side
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`TILE_ADDR_W-1:0] paddr_i,
  input  logic [`TILE_DATA_W-1:0] pwdata_i,
  input  logic [`TILE_STRB_W-1:0] pstrb_i,
  output logic                    pready_o,
  output logic [`TILE_DATA_W-1:0] prdata_o,
  output logic                    pslverr_o,
  // APB requester toward external memory
  output logic                    l2_psel_o,
  output logic                    l2_penable_o,
  output logic                    l2_pwrite_o,
  output logic [`TILE_ADDR_W-1:0] l2_paddr_o,
  output logic [`TILE_DATA_W-1:0] l2_pwdata_o,
  output logic [`TILE_STRB_W-1:0] l2_pstrb_o,
  input  logic                    l2_pready_i,
  input  logic [`TILE_DATA_W-1:0] l2_prdata_i,
  input  logic                    l2_pslverr_i
);

  logic                    tile_enable; // Transfer gate, one cycle behind the input
  tile_mem_pkg::tile_req_t l1_req;
  tile_mem_pkg::tile_rsp_t l1_rsp;
  tile_mem_pkg::tile_req_t l2_req;
  tile_mem_pkg::tile_rsp_t l2_rsp;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) tile_enable <= 1'b0;
    else         tile_enable <= tile_enable_i;
  end

  tile_addr_decode i_tile_addr_decode (
    .clk_i     ( clk_i       ),
    .rstn_i    ( rstn_i      ),
    .enable_i  ( tile_enable ),
    .psel_i    ( psel_i      ),
    .penable_i ( penable_i   ),
    .pwrite_i  ( pwrite_i    ),
    .paddr_i   ( paddr_i     ),
    .pwdata_i  ( pwdata_i    ),
    .pstrb_i   ( pstrb_i     ),
    .pready_o  ( pready_o    ),
    .prdata_o  ( prdata_o    ),
    .pslverr_o ( pslverr_o   ),
    .l1_req_o  ( l1_req      ),
    .l2_req_o  ( l2_req      ),
    .l1_rsp_i  ( l1_rsp      ),
    .l2_rsp_i  ( l2_rsp      )
  );

  tile_l1_spm i_tile_l1_spm (
    .clk_i  ( clk_i  ),
    .rstn_i ( rstn_i ),
    .req_i  ( l1_req ),
    .rsp_o  ( l1_rsp )
  );

  tile_l2_bridge i_tile_l2_bridge (
    .clk_i        ( clk_i        ),
    .rstn_i       ( rstn_i       ),
    .req_i        ( l2_req       ),
    .rsp_o        ( l2_rsp       ),
    .l2_psel_o    ( l2_psel_o    ),
    .l2_penable_o ( l2_penable_o ),
    .l2_pwrite_o  ( l2_pwrite_o  ),
    .l2_paddr_o   ( l2_paddr_o   ),
    .l2_pwdata_o  ( l2_pwdata_o  ),
    .l2_pstrb_o   ( l2_pstrb_o   ),
    .l2_pready_i  ( l2_pready_i  ),
    .l2_prdata_i  ( l2_prdata_i  ),
    .l2_pslverr_i ( l2_pslverr_i )
  );

endmodule

`default_nettype wire

// ==== hw/tile_l2_bridge.sv ====
// L2 bridge; turns each L2 request into an APB requester transfer and returns its result
`timescale 1ns/1ps
`default_nettype none

`include "tile_mem_config.svh"

module tile_l2_bridge (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  input  tile_mem_pkg::tile_req_t req_i,
  output tile_mem_pkg::tile_rsp_t rsp_o,
  output logic                    l2_psel_o,
  output logic                    l2_penable_o,
  output logic                    l2_pwrite_o,
  output logic [`TILE_ADDR_W-1:0] l2_paddr_o,
  output logic [`TILE_DATA_W-1:0] l2_pwdata_o,
  output logic [`TILE_STRB_W-1:0] l2_pstrb_o,
  input  logic                    l2_pready_i,
  input  logic [`TILE_DATA_W-1:0] l2_prdata_i,
  input  logic                    l2_pslverr_i
);

  localparam int unsigned ADDR_W = `TILE_ADDR_W;

  typedef enum logic [1:0] {
    L2_IDLE   = 2'd0, // Waiting for valid
    L2_SETUP  = 2'd1, // psel high, penable low
    L2_ACCESS = 2'd2, // Both high until pready
    L2_DONE   = 2'd3  // Ready pulse back to decode
  } l2_state_e;

  l2_state_e               state_q;
  l2_state_e               state_d;
  logic [`TILE_DATA_W-1:0] rdata_q;
  logic                    err_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      L2_IDLE:   if (req_i.valid) state_d = L2_SETUP; // Setup one cycle after valid
      L2_SETUP:  state_d = L2_ACCESS;
      L2_ACCESS: if (l2_pready_i) state_d = L2_DONE;  // L2 wait states end here
      L2_DONE:   state_d = L2_IDLE;                   // Decode drops valid on this edge
      default:   state_d = L2_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= L2_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Result captured on the completing edge
  always_ff @(posedge clk_i) begin
    if (state_q == L2_ACCESS && l2_pready_i) begin
      rdata_q <= l2_prdata_i;
      err_q   <= l2_pslverr_i; // Passed through as error
    end
  end

  // Control from the state, payload from the held request
  assign l2_psel_o    = (state_q == L2_SETUP) | (state_q == L2_ACCESS);
  assign l2_penable_o = (state_q == L2_ACCESS);
  assign l2_pwrite_o  = req_i.write;
  assign l2_paddr_o   = `TILE_L2_BASE + ADDR_W'(req_i.addr.l2.offset); // Rebased offset
  assign l2_pwdata_o  = req_i.wdata;
  assign l2_pstrb_o   = req_i.strb;

  assign rsp_o.ready = (state_q == L2_DONE);
  assign rsp_o.error = err_q;
  assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hw/tile_l1_spm.sv ====
// Word-interleaved banked L1 scratchpad; byte-strobed writes, reads answered one cycle later
`timescale 1ns/1ps
`default_nettype none

`include "tile_mem_config.svh"

module tile_l1_spm (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  input  tile_mem_pkg::tile_req_t req_i,
  output tile_mem_pkg::tile_rsp_t rsp_o
);

  localparam int unsigned BANKS  = `TILE_L1_BANKS;
  localparam int unsigned WORDS  = `TILE_L1_WORDS;
  localparam int unsigned DATA_W = `TILE_DATA_W;
  localparam int unsigned STRB_W = `TILE_STRB_W;
  localparam int unsigned BANK_W = tile_mem_pkg::L1_BANK_W;

  tile_mem_pkg::tile_addr_u    addr;
  logic                        accept;     // Request taken this cycle
  logic                        ready_q;    // Answer pulse
  logic [BANK_W-1:0]           bank_q;     // Bank whose data is returned
  logic [BANKS-1:0]            bank_sel;
  logic [BANKS-1:0][DATA_W-1:0] bank_rdata;

  assign addr = req_i.addr;

  // Valid stays up in the answer cycle, so skip it there
  assign accept = req_i.valid & ~ready_q;

  for (genvar b = 0; b < BANKS; b++) begin : g_bank
    logic [DATA_W-1:0] mem [WORDS];
    logic [DATA_W-1:0] rdata_q;

    // Scratchpad powers up as all ones in simulation
    initial begin
      for (int r = 0; r < WORDS; r++) begin
        mem[r] = '1;
      end
    end

    assign bank_sel[b]   = accept & (addr.l1.bank == BANK_W'(b));
    assign bank_rdata[b] = rdata_q;

    always_ff @(posedge clk_i) begin
      if (bank_sel[b]) begin
        if (req_i.write) begin
          for (int i = 0; i < STRB_W; i++) begin
            if (req_i.strb[i]) mem[addr.l1.row][8*i +: 8] <= req_i.wdata[8*i +: 8]; // Lane
          end
        end else begin
          rdata_q <= mem[addr.l1.row];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept; // Single-cycle access
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) bank_q <= addr.l1.bank;
  end

  // Answer mux, no error source in the scratchpad
  assign rsp_o.ready = ready_q;
  assign rsp_o.error = 1'b0;
  assign rsp_o.rdata = bank_rdata[bank_q];

endmodule

`default_nettype wire

// ==== hw/tile_addr_decode.sv ====
// APB completer and decode stage; classifies each transfer, holds it and returns the answer
`timescale 1ns/1ps
`default_nettype none

`include "tile_mem_config.svh"

module tile_addr_decode (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  input  logic                    enable_i,  // Registered tile enable
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`TILE_ADDR_W-1:0] paddr_i,
  input  logic [`TILE_DATA_W-1:0] pwdata_i,
  input  logic [`TILE_STRB_W-1:0] pstrb_i,
  output logic                    pready_o,
  output logic [`TILE_DATA_W-1:0] prdata_o,
  output logic                    pslverr_o,
  output tile_mem_pkg::tile_req_t l1_req_o,
  output tile_mem_pkg::tile_req_t l2_req_o,
  input  tile_mem_pkg::tile_rsp_t l1_rsp_i,
  input  tile_mem_pkg::tile_rsp_t l2_rsp_i
);

  localparam logic [`TILE_ADDR_W-1:0] L1_END = `TILE_L1_BASE + `TILE_L1_SIZE; // Exclusive
  localparam logic [`TILE_ADDR_W-1:0] L2_END = `TILE_L2_BASE + `TILE_L2_SIZE;

  tile_mem_pkg::tile_addr_u   addr_in;  // Setup-cycle address
  tile_mem_pkg::tile_target_e tgt_in;   // Its classification
  tile_mem_pkg::tile_req_t    hold_q;   // Transfer held until completion
  tile_mem_pkg::tile_rsp_t    rsp_sel;  // Answer of the addressed target
  tile_mem_pkg::tile_rsp_t    rsp_q;    // Answer parked while the tile is disabled
  tile_mem_pkg::tile_rsp_t    rsp_out;
  logic busy_q;   // A transfer is held
  logic valid_q;  // Issued to its target, not yet answered
  logic done_q;   // Target answered, completion waits for enable
  logic setup;
  logic access;
  logic issue;
  logic tgt_done;
  logic err_flag;

  assign addr_in = paddr_i;
  assign setup   = psel_i & ~penable_i & ~busy_q; // New transfer in its setup cycle
  assign access  = psel_i & penable_i;

  // Address map, the only window check in the tile
  always_comb begin
    if (addr_in.raw >= `TILE_L1_BASE && addr_in.raw < L1_END) begin
      tgt_in = tile_mem_pkg::TGT_L1;
    end else if (addr_in.raw >= `TILE_L2_BASE && addr_in.raw < L2_END) begin
      tgt_in = tile_mem_pkg::TGT_L2;
    end else begin
      tgt_in = tile_mem_pkg::TGT_ERR;
    end
  end

  // Issue straight from setup, or later once enable returns
  always_comb begin
    if (setup) begin
      issue = enable_i & (tgt_in != tile_mem_pkg::TGT_ERR);
    end else begin
      issue = enable_i & busy_q & ~valid_q & ~done_q &
              (hold_q.target != tile_mem_pkg::TGT_ERR);
    end
  end

  assign rsp_sel  = (hold_q.target == tile_mem_pkg::TGT_L2) ? l2_rsp_i : l1_rsp_i;
  assign tgt_done = valid_q & rsp_sel.ready;
  assign err_flag = busy_q & (hold_q.target == tile_mem_pkg::TGT_ERR); // Never forwarded
  assign rsp_out  = done_q ? rsp_q : rsp_sel;

  // Completion only in an access cycle with the tile enabled
  assign pready_o  = access & enable_i & (done_q | tgt_done | err_flag);
  assign pslverr_o = pready_o & (err_flag | rsp_out.error);
  assign prdata_o  = err_flag ? '0 : rsp_out.rdata;

  // Only the addressed stage sees valid
  always_comb begin
    l1_req_o       = hold_q;
    l1_req_o.valid = valid_q & (hold_q.target == tile_mem_pkg::TGT_L1);
    l2_req_o       = hold_q;
    l2_req_o.valid = valid_q & (hold_q.target == tile_mem_pkg::TGT_L2);
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      if (setup) busy_q <= 1'b1;
      else if (pready_o) busy_q <= 1'b0;
      if (issue) valid_q <= 1'b1;
      else if (tgt_done) valid_q <= 1'b0; // Target pulses ready once
      if (tgt_done && !pready_o) done_q <= 1'b1; // Gate closed, park the answer
      else if (pready_o) done_q <= 1'b0;
    end
  end

  // Payload captured in setup, stable for the whole transfer
  always_ff @(posedge clk_i) begin
    if (setup) begin
      hold_q.valid  <= 1'b0; // Valid comes from valid_q
      hold_q.write  <= pwrite_i;
      hold_q.target <= tgt_in;
      hold_q.addr   <= addr_in;
      hold_q.wdata  <= pwdata_i;
      hold_q.strb   <= pstrb_i;
    end
    if (tgt_done && !pready_o) rsp_q <= rsp_sel;
  end

endmodule

`default_nettype wire

// ==== hw/tile_mem_pkg.sv ====
// Shared types of the tile memory system: address views, stage request and response, targets
`default_nettype none

`include "tile_mem_config.svh"

package tile_mem_pkg;

  // Field widths of the two address views
  localparam int unsigned ADDR_W    = `TILE_ADDR_W;
  localparam int unsigned L1_OFF_W  = $clog2(`TILE_STRB_W);   // Byte inside a word
  localparam int unsigned L1_BANK_W = $clog2(`TILE_L1_BANKS); // Low word bits pick the bank
  localparam int unsigned L1_ROW_W  = $clog2(`TILE_L1_WORDS); // Next bits pick the row
  localparam int unsigned L1_PAD_W  = ADDR_W - L1_ROW_W - L1_BANK_W - L1_OFF_W;
  localparam int unsigned L2_OFF_W  = $clog2(`TILE_L2_SIZE);  // Flat offset in the L2 window
  localparam int unsigned L2_PAD_W  = ADDR_W - L2_OFF_W;

  // Destination of a transfer
  typedef enum logic [1:0] {
    TGT_L1  = 2'd0, // Local scratchpad
    TGT_L2  = 2'd1, // External memory through the bridge
    TGT_ERR = 2'd2  // Unmapped, answered with an error
  } tile_target_e;

  // L1 view of an address
  typedef struct packed {
    logic [L1_PAD_W-1:0]  pad;      // Window bits, checked by the decoder
    logic [L1_ROW_W-1:0]  row;
    logic [L1_BANK_W-1:0] bank;
    logic [L1_OFF_W-1:0]  byte_off; // Ignored, word accesses only
  } tile_l1_addr_t;

  // L2 view of an address
  typedef struct packed {
    logic [L2_PAD_W-1:0] pad;    // Window bits
    logic [L2_OFF_W-1:0] offset; // Byte offset from the L2 base
  } tile_l2_addr_t;

  // One address word, read through whichever view the target needs
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    tile_l1_addr_t     l1;
    tile_l2_addr_t     l2;
  } tile_addr_u;

  // Decode stage to target stage
  typedef struct packed {
    logic                    valid;  // Held until the target's ready
    logic                    write;
    tile_target_e            target;
    tile_addr_u              addr;
    logic [`TILE_DATA_W-1:0] wdata;
    logic [`TILE_STRB_W-1:0] strb;
  } tile_req_t;

  // Target stage back to decode stage
  typedef struct packed {
    logic                    ready; // One-cycle pulse
    logic                    error;
    logic [`TILE_DATA_W-1:0] rdata;
  } tile_rsp_t;

endpackage

`default_nettype wire

// ==== hw/tile_mem_config.svh ====
// Widths, L1 bank geometry and address map of the tile memory system; include where needed
`ifndef TILE_MEM_CONFIG_SVH
`define TILE_MEM_CONFIG_SVH

// Bus widths
`define TILE_ADDR_W 32 // Byte address
`define TILE_DATA_W 32 // One word per transfer
`define TILE_STRB_W 4  // One strobe per byte lane

// L1 scratchpad geometry, word interleaved across banks
`define TILE_L1_BANKS 4
`define TILE_L1_WORDS 64 // Rows per bank

// Address map
`define TILE_L1_BASE 32'h1000_0000
`define TILE_L1_SIZE (`TILE_L1_BANKS * `TILE_L1_WORDS * `TILE_STRB_W) // 1 KiB
`define TILE_L2_BASE 32'h8000_0000
`define TILE_L2_SIZE 32'h0000_1000 // 4 KiB

`endif
